// File: hdl/arith_pkg.sv
`default_nettype none

package arith_pkg;

    // operand and result width of the unit
    localparam int XLEN = 32;

    // full unsigned product width
    // the multiplier fills all of it
    localparam int PLEN = 2 * XLEN;

    // restoring divider resolves one quotient bit per step
    localparam int DIV_STEPS = XLEN;

    // step counter must hold DIV_STEPS itself
    // so one bit more than log2(XLEN)
    localparam int STEP_W = 6;

endpackage : arith_pkg

`default_nettype wire

// File: hdl/multdiv_pkg.sv
`default_nettype none

package multdiv_pkg;

    import arith_pkg::*;

    // operation held while the unit is busy
    typedef enum logic {
        MD_MUL = 1'b0,
        MD_DIV = 1'b1
    } md_op_e;

    // request captured on the start strobe
    typedef struct packed {
        md_op_e          op;
        logic [XLEN-1:0] operand_a;
        logic [XLEN-1:0] operand_b;
    } md_req_t;

    // registered response, held until the next completion
    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            exception;
    } md_resp_t;

    // unsigned divider result
    typedef struct packed {
        logic [XLEN-1:0] quotient;
        logic [XLEN-1:0] remainder;
    } div_out_t;

endpackage : multdiv_pkg

`default_nettype wire

// File: hdl/wallace_32.sv
`timescale 1ns/1ps
`default_nettype none

module wallace_32
    import arith_pkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [PLEN-1:0] product
);

    // partial products, row i is a gated by b[i]
    logic [XLEN-1:0] pp [XLEN];

    // running carry-save pair after each row has been added
    // carry bit j weighs 2^(j+1)
    logic [PLEN-1:0] row_sum   [XLEN];
    logic [PLEN-1:0] row_carry [XLEN];

    // final carry-propagate stage
    logic [PLEN-1:0] fin_sum;
    logic [PLEN-1:0] fin_cin;
    logic [PLEN-1:0] ripple;

    genvar i, j, k;

    // AND array
    for (i = 0; i < XLEN; i = i + 1) begin : gen_pp_row
        for (j = 0; j < XLEN; j = j + 1) begin : gen_pp_bit
            assign pp[i][j] = a[j] & b[i];
        end
    end

    // first row seeds the sum, no carries yet
    assign row_sum[0]   = {{(PLEN-XLEN){1'b0}}, pp[0]};
    assign row_carry[0] = '0;

    // fold each shifted row into the sum/carry pair
    for (i = 1; i < XLEN; i = i + 1) begin : gen_csa_row
        logic [PLEN-1:0] shifted;
        logic [PLEN-1:0] cin_vec;

        assign shifted = PLEN'(pp[i]) << i;
        // previous carries line up one bit to the left
        assign cin_vec = {row_carry[i-1][PLEN-2:0], 1'b0};

        for (j = 0; j < PLEN; j = j + 1) begin : gen_fa
            // plain full adder per bit
            assign row_sum[i][j] = row_sum[i-1][j] ^ shifted[j] ^ cin_vec[j];
            assign row_carry[i][j] = (row_sum[i-1][j] & shifted[j])
                                   | (cin_vec[j] & (row_sum[i-1][j] ^ shifted[j]));
        end
    end

    // last row still in redundant form
    assign fin_sum = row_sum[XLEN-1];
    assign fin_cin = {row_carry[XLEN-1][PLEN-2:0], 1'b0};

    // ripple chain, no carry into bit 0
    assign ripple[0] = 1'b0;

    for (k = 0; k < PLEN; k = k + 1) begin : gen_rca_sum
        assign product[k] = fin_sum[k] ^ fin_cin[k] ^ ripple[k];
    end

    // carry out of the top bit cannot be set for an unsigned 32x32 product
    for (k = 0; k < PLEN - 1; k = k + 1) begin : gen_rca_carry
        assign ripple[k+1] = (fin_sum[k] & fin_cin[k])
                           | (ripple[k] & (fin_sum[k] ^ fin_cin[k]));
    end

endmodule : wallace_32

`default_nettype wire

// File: hdl/restoring_divider.sv
`timescale 1ns/1ps
`default_nettype none

module restoring_divider
    import arith_pkg::*;
    import multdiv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            done,
    output div_out_t        div_out
);

    // partial remainder
    logic [XLEN-1:0] rem;
    // dividend shifts out the top while quotient bits shift in at the bottom
    logic [XLEN-1:0] quo;
    // divisor held for the whole run
    logic [XLEN-1:0] dvs;
    // steps still to go, zero when idle
    logic [STEP_W-1:0] step_cnt;
    logic              busy;

    // one extra bit so the trial subtract shows its sign
    logic [XLEN:0] shifted;
    logic [XLEN:0] trial;
    logic          trial_neg;

    assign busy = (step_cnt != '0);

    // shift in the next dividend bit, then try the subtract
    assign shifted   = {rem, quo[XLEN-1]};
    assign trial     = shifted - {1'b0, dvs};
    assign trial_neg = trial[XLEN];

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                step_cnt <= step_cnt - 1'b1;
                // last step this edge, result valid next cycle
                if (step_cnt == STEP_W'(1)) begin
                    done <= 1'b1;
                end
            end else if (start) begin
                step_cnt <= STEP_W'(DIV_STEPS);
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (busy) begin
            // restore by keeping the shifted value on a negative trial
            if (trial_neg) begin
                rem <= shifted[XLEN-1:0];
            end else begin
                rem <= trial[XLEN-1:0];
            end
            quo <= {quo[XLEN-2:0], ~trial_neg};
        end else if (start) begin
            rem <= '0;
            quo <= dividend;
            dvs <= divisor;
        end
    end

    // registers stay put while idle, so the result holds after done
    assign div_out.quotient  = quo;
    assign div_out.remainder = rem;

endmodule : restoring_divider

`default_nettype wire

// File: hdl/multdiv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module multdiv_ctrl
    import arith_pkg::*;
    import multdiv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ctrl_mult,
    input  logic            ctrl_div,
    input  logic [XLEN-1:0] data_operand_a,
    input  logic [XLEN-1:0] data_operand_b,
    output logic [XLEN-1:0] mul_a,
    output logic [XLEN-1:0] mul_b,
    input  logic [PLEN-1:0] product,
    output logic            div_start,
    output logic [XLEN-1:0] div_dividend,
    output logic [XLEN-1:0] div_divisor,
    input  logic            div_done,
    input  div_out_t        div_out,
    output md_resp_t        resp,
    output logic            result_rdy
);

    md_req_t  req;
    logic     busy;
    logic     accept;
    logic     finish;
    md_resp_t resp_next;

    // sign handling on the latched operands
    logic            neg_a;
    logic            neg_b;
    logic            res_neg;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic            div_zero;

    // signed results
    logic [PLEN-1:0] prod_signed;
    logic [XLEN-1:0] quot_signed;
    logic            mul_ovf;

    // strobes while busy are dropped
    assign accept = !busy && (ctrl_mult || ctrl_div);

    assign neg_a   = req.operand_a[XLEN-1];
    assign neg_b   = req.operand_b[XLEN-1];
    assign res_neg = neg_a ^ neg_b;
    // most negative value maps to 2^31, still right as unsigned
    assign abs_a   = neg_a ? -req.operand_a : req.operand_a;
    assign abs_b   = neg_b ? -req.operand_b : req.operand_b;

    assign div_zero = (req.operand_b == '0);

    // both datapath blocks see the same magnitudes
    assign mul_a        = abs_a;
    assign mul_b        = abs_b;
    assign div_dividend = abs_a;
    assign div_divisor  = abs_b;

    assign prod_signed = res_neg ? -product : product;
    assign quot_signed = res_neg ? -div_out.quotient : div_out.quotient;

    // fits in 32 bits only if the upper half is a copy of bit 31
    assign mul_ovf = !(&prod_signed[PLEN-1:XLEN-1]) && (|prod_signed[PLEN-1:XLEN-1]);

    // multiply and divide by zero finish one edge after the latch
    // a real divide waits for the divider
    assign finish = busy && ((req.op == MD_MUL) || div_zero || div_done);

    always_comb begin
        resp_next = '0;
        if (req.op == MD_MUL) begin
            resp_next.result    = prod_signed[XLEN-1:0];
            resp_next.exception = mul_ovf;
        end else if (div_zero) begin
            // result stays zero
            resp_next.exception = 1'b1;
        end else begin
            resp_next.result = quot_signed;
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (accept) begin
            // multiply wins a double strobe
            req.op        <= ctrl_mult ? MD_MUL : MD_DIV;
            req.operand_a <= data_operand_a;
            req.operand_b <= data_operand_b;
        end
    end

    // busy, divider launch, response and ready pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            div_start  <= 1'b0;
            resp       <= '0;
            result_rdy <= 1'b0;
        end else begin
            div_start  <= 1'b0;
            result_rdy <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                // divider only runs for a nonzero divisor
                div_start <= !ctrl_mult && (data_operand_b != '0);
            end else if (finish) begin
                busy       <= 1'b0;
                resp       <= resp_next;
                result_rdy <= 1'b1;
            end
        end
    end

endmodule : multdiv_ctrl

`default_nettype wire

// File: hdl/multdiv.sv
`timescale 1ns/1ps
`default_nettype none

module multdiv
    import arith_pkg::*;
    import multdiv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ctrl_mult,
    input  logic            ctrl_div,
    input  logic [XLEN-1:0] data_operand_a,
    input  logic [XLEN-1:0] data_operand_b,
    output logic [XLEN-1:0] data_result,
    output logic            data_exception,
    output logic            data_result_rdy
);

    // multiplier side
    logic [XLEN-1:0] mul_a;
    logic [XLEN-1:0] mul_b;
    logic [PLEN-1:0] product;

    // divider side
    logic            div_start;
    logic [XLEN-1:0] div_dividend;
    logic [XLEN-1:0] div_divisor;
    logic            div_done;
    div_out_t        div_out;

    md_resp_t resp;

    multdiv_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_mult      (ctrl_mult),
        .ctrl_div       (ctrl_div),
        .data_operand_a (data_operand_a),
        .data_operand_b (data_operand_b),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .product        (product),
        .div_start      (div_start),
        .div_dividend   (div_dividend),
        .div_divisor    (div_divisor),
        .div_done       (div_done),
        .div_out        (div_out),
        .resp           (resp),
        .result_rdy     (data_result_rdy)
    );

    // combinational unsigned product
    wallace_32 u_mul (
        .a       (mul_a),
        .b       (mul_b),
        .product (product)
    );

    restoring_divider u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .done     (div_done),
        .div_out  (div_out)
    );

    assign data_result    = resp.result;
    assign data_exception = resp.exception;

endmodule : multdiv

`default_nettype wire

// File: testbench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held over 4 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : clk_gen

`default_nettype wire

// File: testbench/multdiv_sva.sv
`timescale 1ns/1ps
`default_nettype none

module multdiv_sva
    import multdiv_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    ctrl_mult,
    input logic    busy,
    input md_req_t req,
    input logic    div_start,
    input logic    div_done,
    input logic    result_rdy
);

    // number of assertion failures so far
    int sva_errors = 0;

    // ready is a single-cycle pulse
    rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        result_rdy |=> !result_rdy)
    else begin
        sva_errors = sva_errors + 1;
        $error("result_rdy stayed high for two cycles");
    end

    // divider traffic only while a divide is in flight
    div_only_in_divide: assert property (@(posedge clk) disable iff (!rst_n)
        (div_start || div_done) |-> (busy && req.op == MD_DIV))
    else begin
        sva_errors = sva_errors + 1;
        $error("div_start or div_done outside a divide");
    end

    // accepted multiply, ready in the cycle after the next edge
    mul_ready_two_edges: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && ctrl_mult) |=> !result_rdy ##1 result_rdy)
    else begin
        sva_errors = sva_errors + 1;
        $error("multiply ready not two edges after the strobe");
    end

endmodule : multdiv_sva

bind multdiv_ctrl multdiv_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_mult  (ctrl_mult),
    .busy       (busy),
    .req        (req),
    .div_start  (div_start),
    .div_done   (div_done),
    .result_rdy (result_rdy)
);

`default_nettype wire

// File: testbench/multdiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module multdiv_tb
    import arith_pkg::*;
    import multdiv_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 100;
    // strobe edge to ready cycle, counted in falling edges
    localparam int MUL_LATENCY = 2;
    localparam int DIV_LATENCY = DIV_STEPS + 3;
    localparam int N_RAND_MUL = 24;
    localparam int N_RAND_DIV = 12;
    localparam int SEED = 31904;
    localparam int BUSY_WINDOW = 60;
    localparam longint INT_MAX_64 = 64'sh0000_0000_7fff_ffff;
    localparam longint INT_MIN_64 = -64'sh0000_0000_8000_0000;

    // one table row, stimulus plus expected response
    typedef struct packed {
        md_op_e          op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp_result;
        logic            exp_exc;
    } vec_t;

    logic            clk;
    logic            rst_n;
    logic            ctrl_mult;
    logic            ctrl_div;
    logic [XLEN-1:0] data_operand_a;
    logic [XLEN-1:0] data_operand_b;
    logic [XLEN-1:0] data_result;
    logic            data_exception;
    logic            data_result_rdy;

    vec_t vectors[$];
    int   check_errors;
    int   timeout_errors;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    multdiv DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl_mult       (ctrl_mult),
        .ctrl_div        (ctrl_div),
        .data_operand_a  (data_operand_a),
        .data_operand_b  (data_operand_b),
        .data_result     (data_result),
        .data_exception  (data_exception),
        .data_result_rdy (data_result_rdy)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // expected response from 64-bit signed arithmetic
    function automatic vec_t make_vec(input md_op_e op, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b);
        vec_t   v;
        longint sa;
        longint sb;
        longint full;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        v.op = op;
        v.a = a;
        v.b = b;
        if (op == MD_MUL) begin
            full = sa * sb;
            v.exp_result = full[XLEN-1:0];
            // outside the 32-bit signed range
            v.exp_exc = (full > INT_MAX_64) || (full < INT_MIN_64);
        end else if (b == '0) begin
            v.exp_result = '0;
            v.exp_exc = 1'b1;
        end else begin
            // truncates toward zero; MIN / -1 wraps back to MIN in the low half
            full = sa / sb;
            v.exp_result = full[XLEN-1:0];
            v.exp_exc = 1'b0;
        end
        return v;
    endfunction

    function automatic void add_vector(input md_op_e op, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
        vectors.push_back(make_vec(op, a, b));
    endfunction

    // random magnitude spread over the whole range
    function automatic logic [XLEN-1:0] rand_operand();
        logic [XLEN-1:0] r;
        r = $urandom() >> ($urandom() % XLEN);
        if ($urandom() % 2 == 1) begin
            r = -r;
        end
        return r;
    endfunction

    function automatic void build_table();
        // multiply corners
        add_vector(MD_MUL, 32'd0, 32'd0);
        add_vector(MD_MUL, 32'd0, 32'hffff_ffff);
        add_vector(MD_MUL, 32'd1, 32'd1);
        add_vector(MD_MUL, 32'hffff_ffff, 32'hffff_ffff);
        add_vector(MD_MUL, 32'd1, 32'hffff_ffff);
        add_vector(MD_MUL, 32'h7fff_ffff, 32'd1);
        add_vector(MD_MUL, 32'h8000_0000, 32'd1);
        add_vector(MD_MUL, 32'h8000_0000, 32'hffff_ffff);
        add_vector(MD_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
        add_vector(MD_MUL, 32'h8000_0000, 32'h8000_0000);
        add_vector(MD_MUL, 32'h7fff_ffff, 32'hffff_ffff);
        add_vector(MD_MUL, -32'sd7, 32'sd6);
        add_vector(MD_MUL, 32'sd12345, -32'sd6789);
        add_vector(MD_MUL, 32'sd46341, 32'sd46341);
        add_vector(MD_MUL, -32'sd46341, 32'sd46340);
        add_vector(MD_MUL, -32'sd65536, 32'sd32768);
        // divide corners
        add_vector(MD_DIV, 32'sd100, 32'sd7);
        add_vector(MD_DIV, -32'sd100, 32'sd7);
        add_vector(MD_DIV, 32'sd100, -32'sd7);
        add_vector(MD_DIV, -32'sd100, -32'sd7);
        add_vector(MD_DIV, 32'sd7, 32'sd100);
        add_vector(MD_DIV, 32'h7fff_ffff, 32'd1);
        add_vector(MD_DIV, 32'h8000_0000, 32'hffff_ffff);
        add_vector(MD_DIV, 32'h8000_0000, 32'd1);
        add_vector(MD_DIV, 32'h8000_0000, 32'h8000_0000);
        add_vector(MD_DIV, 32'h7fff_ffff, 32'h8000_0000);
        add_vector(MD_DIV, 32'd0, 32'sd5);
        add_vector(MD_DIV, -32'sd1, 32'sd2);
        // divide by zero
        add_vector(MD_DIV, 32'sd5, 32'd0);
        add_vector(MD_DIV, 32'd0, 32'd0);
        add_vector(MD_DIV, 32'h8000_0000, 32'd0);
        for (int i = 0; i < N_RAND_MUL; i++) begin
            add_vector(MD_MUL, rand_operand(), rand_operand());
        end
        for (int i = 0; i < N_RAND_DIV; i++) begin
            add_vector(MD_DIV, $urandom(), rand_operand());
        end
    endfunction

    // called on the falling edge right after the strobe edge
    task automatic wait_ready(output int latency);
        int cycles;
        cycles = 1;
        while (data_result_rdy !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        latency = (data_result_rdy === 1'b1) ? cycles : -1;
    endtask

    task automatic apply_vector(input vec_t v, input int idx);
        int latency;
        int exp_latency;
        @(negedge clk);
        data_operand_a = v.a;
        data_operand_b = v.b;
        ctrl_mult = (v.op == MD_MUL);
        ctrl_div = (v.op == MD_DIV);
        @(negedge clk);
        ctrl_mult = 1'b0;
        ctrl_div = 1'b0;
        // scramble operands after the strobe edge
        data_operand_a = ~v.a;
        data_operand_b = ~v.b;
        wait_ready(latency);
        if (latency < 0) begin
            timeout_errors++;
            $display("timeout: vector %0d (%s %h, %h) got no data_result_rdy in %0d cycles",
                     idx, v.op.name(), v.a, v.b, TIMEOUT_CYCLES);
        end else begin
            exp_latency = (v.op == MD_DIV && v.b != '0) ? DIV_LATENCY : MUL_LATENCY;
            check_value($sformatf("vec %0d data_result", idx), data_result, v.exp_result);
            check_value($sformatf("vec %0d data_exception", idx), data_exception, v.exp_exc);
            check_value($sformatf("vec %0d ready latency", idx), latency, exp_latency);
            @(negedge clk);
            check_value($sformatf("vec %0d data_result_rdy width", idx), data_result_rdy, 1'b0);
            check_value($sformatf("vec %0d data_result hold", idx), data_result, v.exp_result);
        end
    endtask

    // strobes during a divide must vanish
    task automatic check_busy_drop();
        vec_t            first;
        vec_t            intruder;
        int              pulses;
        logic [XLEN-1:0] got_result;
        got_result = '0;
        pulses = 0;
        first = make_vec(MD_DIV, -32'sd1000, 32'sd7);
        intruder = make_vec(MD_MUL, 32'sd3, 32'sd4);
        @(negedge clk);
        data_operand_a = first.a;
        data_operand_b = first.b;
        ctrl_div = 1'b1;
        @(negedge clk);
        for (int c = 1; c <= BUSY_WINDOW; c++) begin
            if (data_result_rdy === 1'b1) begin
                pulses++;
                got_result = data_result;
            end
            data_operand_a = intruder.a;
            data_operand_b = intruder.b;
            ctrl_mult = (c == 3) || (c == 20);
            ctrl_div = (c == 10);
            @(negedge clk);
        end
        check_value("busy drop ready pulse count", pulses, 1);
        check_value("busy drop data_result", got_result, first.exp_result);
    endtask

    initial begin
        int waited;
        int sva_fails;
        ctrl_mult = 1'b0;
        ctrl_div = 1'b0;
        data_operand_a = '0;
        data_operand_b = '0;
        check_errors = 0;
        timeout_errors = 0;
        void'($urandom(SEED));
        build_table();
        waited = 0;
        while (rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            timeout_errors++;
            $display("timeout: reset was never released");
        end else begin
            @(negedge clk);
            check_value("data_result_rdy after reset", data_result_rdy, 1'b0);
            check_value("data_exception after reset", data_exception, 1'b0);
            check_value("data_result after reset", data_result, '0);
            foreach (vectors[i]) begin
                apply_vector(vectors[i], i);
            end
            check_busy_drop();
        end
        sva_fails = DUT.u_ctrl.u_sva.sva_errors;
        $display("summary: %0d vectors, %0d check errors, %0d timeouts, %0d assertion errors",
                 vectors.size(), check_errors, timeout_errors, sva_fails);
        if (check_errors == 0 && timeout_errors == 0 && sva_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : multdiv_tb

`default_nettype wire

// File: multdiv.f
hdl/arith_pkg.sv
hdl/multdiv_pkg.sv
hdl/wallace_32.sv
hdl/restoring_divider.sv
hdl/multdiv_ctrl.sv
hdl/multdiv.sv
testbench/clk_gen.sv
testbench/multdiv_sva.sv
testbench/multdiv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator and run, pass is judged from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal --top-module multdiv_tb \
    -f multdiv.f -o multdiv_sim > "$log" 2>&1 \
    && ./obj_dir/multdiv_sim +verilator+error+limit+100 >> "$log" 2>&1 \
    || echo "build or simulation returned an error, see $log"

grep -qx "Simulation PASSED" "$log" \
    && { echo "run passed"; exit 0; } \
    || { echo "run failed, see $log"; exit 1; }
